/* cpu.f */
+incdir+common
common/cpu_pkg.sv
src/register_file.sv
src/cdb_arbiter.sv
reorder_buffer/reorder_buffer.sv
exec/alu_combo.sv
exec/mult_div_combo.sv
src/cpu.sv
bench/cpu_tb.sv

/* Bender.yml */
package:
  name: cpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpu_pkg.sv
      - src/register_file.sv
      - src/cdb_arbiter.sv
      - reorder_buffer/reorder_buffer.sv
      - exec/alu_combo.sv
      - exec/mult_div_combo.sv
      - src/cpu.sv
      - target: test
        files:
          - bench/cpu_tb.sv

/* bench/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

  localparam int ISSUE_LIMIT = 500;   // cycles an instruction may wait for issue_ready.
  localparam int DRAIN_LIMIT = 3000;  // cycles allowed for the pending work to retire.

  logic             clock;
  logic             reset;
  logic             issue_valid;
  cpu_pkg::issue_t  issue;
  logic             issue_ready;
  cpu_pkg::commit_t commit;

  cpu_pkg::word_t   ref_regs [`REG_COUNT];
  cpu_pkg::commit_t expected_q [$];
  int               issue_seq;
  int               error_count;
  int               timeout_count;
  logic             saw_stall;

  cpu i_cpu (
    .clock      (clock),
    .reset      (reset),
    .issue_valid(issue_valid),
    .issue      (issue),
    .issue_ready(issue_ready),
    .commit     (commit)
  );

  always #10 clock = ~clock;

  // ========================================
  // reference model and issue driver
  // ========================================

  function automatic cpu_pkg::word_t model_result(input cpu_pkg::op_e op,
                                                  input cpu_pkg::word_t a,
                                                  input cpu_pkg::word_t b);
    case (op)
      cpu_pkg::ADD: return a + b;
      cpu_pkg::SUB: return a - b;
      cpu_pkg::AND: return a & b;
      cpu_pkg::OR:  return a | b;
      cpu_pkg::XOR: return a ^ b;
      cpu_pkg::MUL: return a * b;  // low half of the product.
      default:      return (b == '0) ? '1 : a / b;
    endcase
  endfunction

  // called right after a falling edge, returns right after a later one.
  task automatic issue_instr(input cpu_pkg::op_e op, input int rd, input int rs1,
                             input int rs2, input logic use_imm, input cpu_pkg::word_t imm);
    cpu_pkg::commit_t exp;
    cpu_pkg::word_t   b;
    int               waited;
    issue_valid   = 1'b1;
    issue.op      = op;
    issue.rd      = cpu_pkg::reg_t'(rd);
    issue.rs1     = cpu_pkg::reg_t'(rs1);
    issue.rs2     = cpu_pkg::reg_t'(rs2);
    issue.use_imm = use_imm;
    issue.imm     = imm;
    #1;
    waited = 0;
    if (!issue_ready) saw_stall = 1'b1;
    while (!issue_ready && waited < ISSUE_LIMIT) begin
      @(negedge clock);
      #1;
      waited++;
    end
    if (issue_ready) begin
      b         = use_imm ? imm : ref_regs[rs2];
      exp.valid = 1'b1;
      exp.rd    = cpu_pkg::reg_t'(rd);
      exp.tag   = cpu_pkg::tag_t'(issue_seq);  // tags follow issue order round the buffer.
      exp.value = model_result(op, ref_regs[rs1], b);
      expected_q.push_back(exp);
      if (rd != 0) ref_regs[rd] = exp.value;
      issue_seq++;
    end else begin
      $display("%s to x%0d was never accepted, issue_ready stayed low for %0d cycles",
               op.name(), rd, ISSUE_LIMIT);
      timeout_count++;
    end
    @(negedge clock);
    issue_valid = 1'b0;
  endtask

  task automatic issue_reg(input cpu_pkg::op_e op, input int rd, input int rs1, input int rs2);
    issue_instr(op, rd, rs1, rs2, 1'b0, '0);
  endtask

  task automatic issue_imm(input cpu_pkg::op_e op, input int rd, input int rs1,
                           input cpu_pkg::word_t imm);
    issue_instr(op, rd, rs1, 0, 1'b1, imm);
  endtask

  task automatic wait_drain(input string what);
    int waited;
    waited = 0;
    while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clock);
      #1;
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("%s stalled with %0d instructions never committed", what, expected_q.size());
      timeout_count++;
      expected_q.delete();
    end
    @(negedge clock);
  endtask

  // ========================================
  // commit monitor
  // ========================================

  task automatic check_commit();
    cpu_pkg::commit_t exp;
    if (expected_q.size() == 0) begin
      $display("a commit to x%0d with value %h arrived while nothing was pending",
               commit.rd, commit.value);
      error_count++;
    end else begin
      exp = expected_q.pop_front();
      if (commit.rd != exp.rd) begin
        $display("CHECK FAILED commit.rd got %h expected %h", commit.rd, exp.rd);
        error_count++;
      end
      if (commit.tag != exp.tag) begin
        $display("CHECK FAILED commit.tag got %h expected %h", commit.tag, exp.tag);
        error_count++;
      end
      if (commit.value != exp.value) begin
        $display("CHECK FAILED commit.value got %h expected %h", commit.value, exp.value);
        error_count++;
      end
    end
  endtask

  always @(negedge clock) begin
    if (!reset && commit.valid) check_commit();  // commit only moves on rising edges.
  end

  // ========================================
  // directed tests
  // ========================================

  task automatic test_reset_state();
    repeat (20) begin
      @(negedge clock);
      if (commit.valid !== 1'b0) begin
        $display("CHECK FAILED commit.valid got %h expected %h", commit.valid, 1'b0);
        error_count++;
      end
    end
    if (issue_ready !== 1'b1) begin
      $display("CHECK FAILED issue_ready got %h expected %h", issue_ready, 1'b1);
      error_count++;
    end
    issue_imm(cpu_pkg::ADD, 0, 0, 32'h0000_0055);  // retires with its value while x0 keeps zero.
    wait_drain("test_reset_state x0 write");
    issue_imm(cpu_pkg::ADD, 1, 0, 32'h0000_0000);
    issue_reg(cpu_pkg::OR, 2, 0, 0);
    wait_drain("test_reset_state");
  endtask

  task automatic test_alu_ops();
    issue_imm(cpu_pkg::ADD, 1, 0, 32'h1234_5678);
    issue_imm(cpu_pkg::ADD, 2, 0, 32'hF0F0_0FF0);
    wait_drain("test_alu_ops setup");
    issue_reg(cpu_pkg::ADD, 3, 1, 2);
    issue_reg(cpu_pkg::SUB, 4, 1, 2);
    issue_reg(cpu_pkg::AND, 5, 1, 2);
    issue_reg(cpu_pkg::OR, 6, 1, 2);
    issue_reg(cpu_pkg::XOR, 7, 1, 2);
    issue_imm(cpu_pkg::ADD, 3, 2, 32'h7FFF_FFFF);
    issue_imm(cpu_pkg::SUB, 4, 1, 32'hFFFF_FFFF);
    issue_imm(cpu_pkg::AND, 5, 2, 32'h0000_FFFF);
    issue_imm(cpu_pkg::OR, 6, 1, 32'h8000_0001);
    issue_imm(cpu_pkg::XOR, 7, 2, 32'hFFFF_FFFF);
    wait_drain("test_alu_ops");
  endtask

  task automatic test_dependency_chain();
    issue_imm(cpu_pkg::ADD, 8, 0, 32'h0000_0003);
    issue_reg(cpu_pkg::ADD, 8, 8, 8);  // reads a result that is still in flight.
    issue_reg(cpu_pkg::ADD, 8, 8, 8);
    issue_imm(cpu_pkg::SUB, 9, 8, 32'h0000_0005);
    issue_reg(cpu_pkg::XOR, 10, 9, 8);
    issue_reg(cpu_pkg::OR, 11, 10, 9);
    issue_reg(cpu_pkg::AND, 12, 11, 8);
    wait_drain("test_dependency_chain");
  endtask

  task automatic test_mult_div();
    issue_imm(cpu_pkg::ADD, 13, 0, 32'd1_000_003);
    issue_imm(cpu_pkg::ADD, 14, 0, 32'd97);
    issue_reg(cpu_pkg::MUL, 15, 13, 14);
    issue_reg(cpu_pkg::DIVU, 16, 13, 14);
    issue_imm(cpu_pkg::ADD, 22, 14, 32'h1);  // finishes early but retires behind the divide.
    issue_imm(cpu_pkg::ADD, 17, 15, 32'h1);
    issue_reg(cpu_pkg::DIVU, 18, 13, 0);
    issue_imm(cpu_pkg::ADD, 19, 18, 32'h1);
    issue_imm(cpu_pkg::MUL, 20, 18, 32'hFFFF_FFFF);
    issue_imm(cpu_pkg::DIVU, 21, 16, 32'h7);
    wait_drain("test_mult_div");
  endtask

  task automatic test_back_pressure();
    saw_stall = 1'b0;
    for (int i = 0; i < 4; i++) begin
      issue_imm(cpu_pkg::DIVU, 23, 13, i + 2);
      issue_imm(cpu_pkg::ADD, 24, 23, i);
      issue_imm(cpu_pkg::XOR, 25, 1, i);
      issue_reg(cpu_pkg::SUB, 26, 25, 24);
    end
    if (!saw_stall) begin
      $display("issue_ready never fell during the divide burst");
      error_count++;
    end
    wait_drain("test_back_pressure");
  endtask

  task automatic test_random_mix();
    cpu_pkg::op_e op;
    for (int n = 0; n < 200; n++) begin
      op = cpu_pkg::op_e'($urandom_range(6, 0));
      issue_instr(op, $urandom_range(7, 0), $urandom_range(7, 0), $urandom_range(7, 0),
                  1'($urandom_range(1, 0)), $urandom);
    end
    wait_drain("test_random_mix");
  endtask

  initial begin
    void'($urandom(11));
    clock         = 1'b0;
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue         = '0;
    issue_seq     = 0;
    error_count   = 0;
    timeout_count = 0;
    saw_stall     = 1'b0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      ref_regs[i] = '0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_reset_state();
    test_alu_ops();
    test_dependency_chain();
    test_mult_div();
    test_back_pressure();
    test_random_mix();
    $display("%0d instructions issued, %0d check errors, %0d timeouts",
             issue_seq, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps

module cpu (
  input  logic             clock,
  input  logic             reset,
  input  logic             issue_valid,
  input  cpu_pkg::issue_t  issue,
  output logic             issue_ready,
  output cpu_pkg::commit_t commit
);

  cpu_pkg::reg_t         query_rs1;
  cpu_pkg::reg_t         query_rs2;
  cpu_pkg::reg_val_t     rs1_val;
  cpu_pkg::reg_val_t     rs2_val;
  cpu_pkg::fullness_t    fullness;
  logic                  issue_fire;
  cpu_pkg::issue_entry_t issue_bus;
  cpu_pkg::cdb_t         data_bus;
  cpu_pkg::cdb_t         alu_request;
  cpu_pkg::cdb_t         mult_div_request;
  logic                  alu_grant;
  logic                  mult_div_grant;

  register_file reg_file (
    .clock     (clock),
    .reset     (reset),
    .query_rs1 (query_rs1),
    .query_rs2 (query_rs2),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .issue_fire(issue_fire),
    .issue_rd  (issue.rd),
    .issue_tag (issue_bus.tag),  // tag of the entry being allocated.
    .commit    (commit)
  );

  reorder_buffer reorder_buffer (
    .clock      (clock),
    .reset      (reset),
    .issue_valid(issue_valid),
    .issue      (issue),
    .issue_ready(issue_ready),
    .query_rs1  (query_rs1),
    .query_rs2  (query_rs2),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .fullness   (fullness),
    .issue_fire (issue_fire),
    .issue_bus  (issue_bus),
    .data_bus   (data_bus),
    .commit     (commit)
  );

  alu_combo alu_combo (
    .clock    (clock),
    .reset    (reset),
    .issue_bus(issue_bus),
    .data_bus (data_bus),
    .grant    (alu_grant),
    .request  (alu_request),
    .full     (fullness.alu)
  );

  mult_div_combo mult_div_combo (
    .clock    (clock),
    .reset    (reset),
    .issue_bus(issue_bus),
    .data_bus (data_bus),
    .grant    (mult_div_grant),
    .request  (mult_div_request),
    .full     (fullness.mult_div)
  );

  cdb_arbiter cdb_arbiter (
    .alu_request     (alu_request),
    .mult_div_request(mult_div_request),
    .alu_grant       (alu_grant),
    .mult_div_grant  (mult_div_grant),
    .data_bus        (data_bus)
  );

endmodule

/* exec/mult_div_combo.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module mult_div_combo (
  input  logic                  clock,
  input  logic                  reset,
  input  cpu_pkg::issue_entry_t issue_bus,
  input  cpu_pkg::cdb_t         data_bus,
  input  logic                  grant,
  output cpu_pkg::cdb_t         request,
  output logic                  full
);

  cpu_pkg::issue_entry_t   entry;
  logic                    capture;
  logic                    start;
  logic                    running;
  logic [$clog2(`XLEN):0]  count;
  cpu_pkg::word_t          product;
  cpu_pkg::word_t          quotient;
  cpu_pkg::word_t          remainder;
  cpu_pkg::word_t          next_quotient;
  cpu_pkg::word_t          next_remainder;
  logic [`XLEN:0]          rem_shift;
  logic [`XLEN:0]          diff;

  assign capture = issue_bus.valid && issue_bus.op inside {cpu_pkg::MUL, cpu_pkg::DIVU};
  assign full    = entry.valid && !grant;  // held until the result leaves on the bus.
  assign start   = entry.valid && entry.a.ready && entry.b.ready && !running && !request.valid;
  assign product = entry.a.value * entry.b.value;  // low half only.

  // ========================================
  // restoring divider, one quotient bit per cycle
  // ========================================

  assign rem_shift      = {remainder, quotient[`XLEN-1]};
  assign diff           = rem_shift - {1'b0, entry.b.value};
  assign next_quotient  = {quotient[`XLEN-2:0], !diff[`XLEN]};
  assign next_remainder = diff[`XLEN] ? rem_shift[`XLEN-1:0] : diff[`XLEN-1:0];
  // a zero divisor never borrows, so every quotient bit comes out set.

  always_ff @(posedge clock) begin
    if (reset) begin
      entry.valid   <= 1'b0;
      request.valid <= 1'b0;
      running       <= 1'b0;
    end else begin
      entry.a <= cpu_pkg::wake_operand(entry.a, data_bus);
      entry.b <= cpu_pkg::wake_operand(entry.b, data_bus);
      if (grant) begin
        entry.valid   <= 1'b0;
        request.valid <= 1'b0;
      end
      if (capture) entry <= issue_bus;
      if (start && entry.op == cpu_pkg::MUL) begin
        request.valid <= 1'b1;
        request.tag   <= entry.tag;
        request.value <= product;
      end
      if (start && entry.op == cpu_pkg::DIVU) begin
        running   <= 1'b1;
        count     <= `XLEN;
        quotient  <= entry.a.value;  // dividend shifts out as quotient shifts in.
        remainder <= '0;
      end
      if (running) begin
        quotient  <= next_quotient;
        remainder <= next_remainder;
        count     <= count - 1'b1;
        if (count == 1) begin
          running       <= 1'b0;
          request.valid <= 1'b1;
          request.tag   <= entry.tag;
          request.value <= next_quotient;
        end
      end
    end
  end

endmodule

/* exec/alu_combo.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu_combo (
  input  logic                  clock,
  input  logic                  reset,
  input  cpu_pkg::issue_entry_t issue_bus,
  input  cpu_pkg::cdb_t         data_bus,
  input  logic                  grant,
  output cpu_pkg::cdb_t         request,
  output logic                  full
);

  typedef logic [$clog2(`ALU_RS_DEPTH)-1:0] slot_t;

  cpu_pkg::issue_entry_t    entries [`ALU_RS_DEPTH];
  logic [`ALU_RS_DEPTH-1:0] occupied;
  logic [`ALU_RS_DEPTH-1:0] ready;
  slot_t                    oldest;
  slot_t                    next_oldest;
  slot_t                    sel;
  slot_t                    slot;
  logic                     fire;
  logic                     capture;
  cpu_pkg::word_t           a;
  cpu_pkg::word_t           b;
  cpu_pkg::word_t           result;

  always_comb begin
    slot = sel;  // with every slot taken only the one leaving is free.
    for (int i = `ALU_RS_DEPTH - 1; i >= 0; i--) begin
      occupied[i] = entries[i].valid;
      ready[i]    = entries[i].valid && entries[i].a.ready && entries[i].b.ready;
      if (!entries[i].valid) slot = slot_t'(i);
    end
  end

  assign sel     = ready[oldest] ? oldest : ~oldest;
  assign fire    = (|ready) && (!request.valid || grant);
  assign full    = (&occupied) && !fire;
  assign capture = issue_bus.valid
      && issue_bus.op inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR};

  always_comb begin
    next_oldest = oldest;
    if (capture) begin
      next_oldest = (occupied[~slot] && !(fire && sel == ~slot)) ? ~slot : slot;
    end else if (fire && sel == oldest) begin
      next_oldest = ~oldest;
    end
  end

  // ========================================
  // execute
  // ========================================

  assign a = entries[sel].a.value;
  assign b = entries[sel].b.value;

  always_comb begin
    case (entries[sel].op)
      cpu_pkg::ADD: result = a + b;  // wraps at 32 bits.
      cpu_pkg::SUB: result = a - b;
      cpu_pkg::AND: result = a & b;
      cpu_pkg::OR:  result = a | b;
      default:      result = a ^ b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ALU_RS_DEPTH; i++) begin
        entries[i].valid <= 1'b0;
      end
      oldest        <= '0;
      request.valid <= 1'b0;
    end else begin
      for (int i = 0; i < `ALU_RS_DEPTH; i++) begin
        entries[i].a <= cpu_pkg::wake_operand(entries[i].a, data_bus);
        entries[i].b <= cpu_pkg::wake_operand(entries[i].b, data_bus);
      end
      if (fire) begin
        entries[sel].valid <= 1'b0;
        request.valid      <= 1'b1;
        request.tag        <= entries[sel].tag;
        request.value      <= result;
      end else if (grant) begin
        request.valid <= 1'b0;
      end
      if (capture) entries[slot] <= issue_bus;
      oldest <= next_oldest;
    end
  end

  request_held: assert property (@(posedge clock) disable iff (reset)
      request.valid && !grant |=> request.valid && $stable(request));

endmodule

/* reorder_buffer/reorder_buffer.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  issue_valid,
  input  cpu_pkg::issue_t       issue,
  output logic                  issue_ready,
  output cpu_pkg::reg_t         query_rs1,
  output cpu_pkg::reg_t         query_rs2,
  input  cpu_pkg::reg_val_t     rs1_val,
  input  cpu_pkg::reg_val_t     rs2_val,
  input  cpu_pkg::fullness_t    fullness,
  output logic                  issue_fire,
  output cpu_pkg::issue_entry_t issue_bus,
  input  cpu_pkg::cdb_t         data_bus,
  output cpu_pkg::commit_t      commit
);

  logic [`ROB_DEPTH-1:0]       rob_valid;
  logic [`ROB_DEPTH-1:0]       rob_done;
  cpu_pkg::reg_t               rob_rd [`ROB_DEPTH];
  cpu_pkg::word_t              rob_value [`ROB_DEPTH];
  cpu_pkg::tag_t               head;
  cpu_pkg::tag_t               tail;
  logic [$clog2(`ROB_DEPTH):0] count;
  logic                        is_mult_div;
  logic                        unit_full;

  // busy registers look up their producer in the buffer, then on the bus.
  function automatic cpu_pkg::operand_t resolve(cpu_pkg::reg_val_t r);
    cpu_pkg::operand_t o;
    o.ready = 1'b1;
    o.tag   = r.tag;
    o.value = r.value;
    if (r.busy) begin
      if (rob_done[r.tag]) begin
        o.value = rob_value[r.tag];
      end else if (data_bus.valid && data_bus.tag == r.tag) begin
        o.value = data_bus.value;
      end else begin
        o.ready = 1'b0;
      end
    end
    return o;
  endfunction

  // ========================================
  // issue and operand resolution
  // ========================================

  assign query_rs1   = issue.rs1;
  assign query_rs2   = issue.rs2;
  assign is_mult_div = issue.op inside {cpu_pkg::MUL, cpu_pkg::DIVU};
  assign unit_full   = is_mult_div ? fullness.mult_div : fullness.alu;
  assign issue_ready = count != `ROB_DEPTH && !unit_full;
  assign issue_fire  = issue_valid && issue_ready;

  always_comb begin
    issue_bus.valid = issue_fire;
    issue_bus.tag   = tail;  // the tail slot is the new rename tag.
    issue_bus.op    = issue.op;
    issue_bus.a     = resolve(rs1_val);
    if (issue.use_imm) begin
      issue_bus.b = '{ready: 1'b1, tag: '0, value: issue.imm};
    end else begin
      issue_bus.b = resolve(rs2_val);
    end
  end

  // ========================================
  // in-order retirement
  // ========================================

  always_comb begin
    commit.valid = rob_valid[head] && rob_done[head];
    commit.rd    = rob_rd[head];
    commit.tag   = head;
    commit.value = rob_value[head];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rob_valid <= '0;
      rob_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (data_bus.valid) begin
        rob_done[data_bus.tag]  <= 1'b1;
        rob_value[data_bus.tag] <= data_bus.value;
      end
      if (commit.valid) begin
        rob_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
      if (issue_fire) begin
        rob_valid[tail] <= 1'b1;
        rob_done[tail]  <= 1'b0;
        rob_rd[tail]    <= issue.rd;
        tail            <= tail + 1'b1;
      end
      count <= count + issue_fire - commit.valid;
    end
  end

  alloc_free_slot: assert property (@(posedge clock) disable iff (reset)
      issue_fire |-> !rob_valid[tail]);

  bus_hits_pending: assert property (@(posedge clock) disable iff (reset)
      data_bus.valid |-> rob_valid[data_bus.tag] && !rob_done[data_bus.tag]);

endmodule

/* src/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
  input  cpu_pkg::cdb_t alu_request,
  input  cpu_pkg::cdb_t mult_div_request,
  output logic          alu_grant,
  output logic          mult_div_grant,
  output cpu_pkg::cdb_t data_bus
);

  // mult/div goes first since its station holds a single entry.
  assign mult_div_grant = mult_div_request.valid;
  assign alu_grant      = alu_request.valid && !mult_div_request.valid;

  always_comb begin
    if (mult_div_grant) begin
      data_bus = mult_div_request;
    end else begin
      data_bus = alu_request;  // valid is low here when nothing is granted.
    end
  end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file (
  input  logic              clock,
  input  logic              reset,
  input  cpu_pkg::reg_t     query_rs1,
  input  cpu_pkg::reg_t     query_rs2,
  output cpu_pkg::reg_val_t rs1_val,
  output cpu_pkg::reg_val_t rs2_val,
  input  logic              issue_fire,
  input  cpu_pkg::reg_t     issue_rd,
  input  cpu_pkg::tag_t     issue_tag,
  input  cpu_pkg::commit_t  commit
);

  cpu_pkg::word_t        values [`REG_COUNT];
  cpu_pkg::tag_t         tags [`REG_COUNT];
  logic [`REG_COUNT-1:0] busy;

  always_comb begin
    rs1_val.busy  = busy[query_rs1];
    rs1_val.tag   = tags[query_rs1];
    rs1_val.value = values[query_rs1];
    rs2_val.busy  = busy[query_rs2];
    rs2_val.tag   = tags[query_rs2];
    rs2_val.value = values[query_rs2];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      for (int i = 0; i < `REG_COUNT; i++) begin
        values[i] <= '0;
      end
    end else begin
      if (commit.valid && commit.rd != '0) begin
        values[commit.rd] <= commit.value;
        if (tags[commit.rd] == commit.tag) busy[commit.rd] <= 1'b0;  // only the last writer frees it.
      end
      if (issue_fire && issue_rd != '0) begin  // placed last so a fresh rename wins.
        busy[issue_rd] <= 1'b1;
        tags[issue_rd] <= issue_tag;
      end
    end
  end

endmodule

/* common/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] tag_t;

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, MUL, DIVU} op_e;

  typedef struct packed {
    op_e   op;
    reg_t  rd;
    reg_t  rs1;
    reg_t  rs2;
    logic  use_imm;
    word_t imm;
  } issue_t;

  typedef struct packed {
    logic  busy;
    tag_t  tag;
    word_t value;
  } reg_val_t;

  typedef struct packed {
    logic  ready;
    tag_t  tag;     // producer tag while the operand waits.
    word_t value;
  } operand_t;

  typedef struct packed {
    logic     valid;
    tag_t     tag;
    op_e      op;
    operand_t a;
    operand_t b;
  } issue_entry_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t value;
  } cdb_t;

  typedef struct packed {
    logic  valid;
    reg_t  rd;
    tag_t  tag;
    word_t value;
  } commit_t;

  typedef struct packed {
    logic alu;
    logic mult_div;
  } fullness_t;

  // a waiting operand picks up its value when its producer shows on the bus.
  function automatic operand_t wake_operand(operand_t o, cdb_t bus);
    operand_t w;
    w = o;
    if (!o.ready && bus.valid && bus.tag == o.tag) begin
      w.ready = 1'b1;
      w.value = bus.value;
    end
    return w;
  endfunction

endpackage

/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// ========================================
// core sizing
// ========================================

`define XLEN 32          // data path width in bits.
`define REG_COUNT 32     // architectural registers.
`define ROB_DEPTH 8      // reorder buffer entries, one tag each.
`define ALU_RS_DEPTH 2   // ALU reservation station entries.

`endif
